//--- source/arcade_glue_pkg.sv
package arcade_glue_pkg;

	// ------------------------------------------------------------------------
	// Status word from the OSD menu
	// ------------------------------------------------------------------------

	typedef struct packed {
		logic [7:0] unused_hi;
		logic [7:0] dsw2;
		logic [7:0] dsw1;
		logic [1:0] unused_mid;
		logic       blend;
		logic [1:0] scanlines;
		logic       rotate;
		logic       unused_lo;
		logic       reset_req;
	} status_fields_t;

	// The menu hands over one 32-bit word, and the core reads it as named fields
	typedef union packed {
		logic [31:0]    raw;
		status_fields_t fields;
	} status_t;

	// ------------------------------------------------------------------------
	// File transfer channel
	// ------------------------------------------------------------------------

	localparam logic [7:0] cmd_file_tx     = 8'h53;
	localparam logic [7:0] cmd_file_tx_dat = 8'h54;
	localparam logic [7:0] cmd_file_index  = 8'h55;

	// Index of the ROM image in the download menu
	localparam logic [7:0] rom_index = 8'h00;

endpackage

//--- source/spi_download.sv
`timescale 1ns/1ns

module spi_download
	import arcade_glue_pkg::*;
#(
	parameter int dl_addr_width = 25
) (
	input  logic                     clk_48,
	input  logic                     reset,
	input  logic                     spi_sck,
	input  logic                     spi_ss2,
	input  logic                     spi_di,
	output logic                     downloading,
	output logic [7:0]               dl_index,
	output logic                     dl_wr,
	output logic [dl_addr_width-1:0] dl_addr,
	output logic [7:0]               dl_data
);

	localparam logic [2:0] st_cmd   = 3'd0;
	localparam logic [2:0] st_index = 3'd1;
	localparam logic [2:0] st_tx    = 3'd2;
	localparam logic [2:0] st_data  = 3'd3;
	localparam logic [2:0] st_skip  = 3'd4;

	logic [1:0] sck_sync;
	logic [1:0] ss_sync;
	logic [1:0] di_sync;
	logic       sck_prev;
	logic       sck_rise;
	logic       frame_active;
	logic       byte_done;
	logic [6:0] shift;
	logic [7:0] rx_byte;
	logic [2:0] bit_cnt;
	logic [2:0] state;
	logic       inc_pending;

	// All three pins go through the same two stages so data stays aligned to SCK
	always_ff @(posedge clk_48) begin
		sck_sync <= {sck_sync[0], spi_sck};
		ss_sync  <= {ss_sync[0], spi_ss2};
		di_sync  <= {di_sync[0], spi_di};
		sck_prev <= sck_sync[1];
	end

	assign sck_rise     = sck_sync[1] & ~sck_prev;
	assign frame_active = ~ss_sync[1];
	assign byte_done    = sck_rise & frame_active & (bit_cnt == 3'd7);
	assign rx_byte      = {shift, di_sync[1]};

	always_ff @(posedge clk_48) begin
		if (sck_rise && frame_active) begin
			shift <= rx_byte[6:0];
		end
	end

	always_ff @(posedge clk_48) begin
		if (byte_done && state == st_data) begin
			dl_data <= rx_byte;
		end
	end

	always_ff @(posedge clk_48) begin
		if (reset) begin
			state       <= st_cmd;
			bit_cnt     <= 3'd0;
			downloading <= 1'b0;
			dl_index    <= 8'h00;
			dl_wr       <= 1'b0;
			dl_addr     <= '0;
			inc_pending <= 1'b0;
		end else begin
			dl_wr <= 1'b0;
			if (!frame_active) begin
				state   <= st_cmd;
				bit_cnt <= 3'd0;
			end else if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				// The address moves on at the first bit of the next byte, so it
				// still holds while the ROM write lands a clock after dl_wr
				if (inc_pending) begin
					dl_addr     <= dl_addr + 1'b1;
					inc_pending <= 1'b0;
				end
				if (bit_cnt == 3'd7) begin
					case (state)
						st_cmd: begin
							if (rx_byte == cmd_file_index) begin
								state <= st_index;
							end else if (rx_byte == cmd_file_tx) begin
								state <= st_tx;
							end else if (rx_byte == cmd_file_tx_dat) begin
								state <= st_data;
							end else begin
								state <= st_skip;
							end
						end
						st_index: begin
							dl_index <= rx_byte;
							state    <= st_skip;
						end
						st_tx: begin
							if (rx_byte != 8'h00) begin
								downloading <= 1'b1;
								dl_addr     <= '0;
							end else begin
								downloading <= 1'b0;
							end
							state <= st_skip;
						end
						st_data: begin
							dl_wr       <= 1'b1;
							inc_pending <= 1'b1;
						end
						default: begin
						end
					endcase
				end
			end
		end
	end

endmodule

//--- source/rom_download_ctrl.sv
`timescale 1ns/1ns

module rom_download_ctrl
	import arcade_glue_pkg::*;
(
	input  logic       clk_48,
	input  logic       reset,
	input  logic       downloading,
	input  logic       dl_wr,
	input  logic [7:0] dl_index,
	input  status_t    status,
	input  logic [1:0] buttons,
	output logic       rom_we,
	output logic       rom_loaded,
	output logic       core_reset
);

	logic downloading_d;

	always_ff @(posedge clk_48) begin
		if (reset) begin
			downloading_d <= 1'b0;
			rom_loaded    <= 1'b0;
		end else begin
			downloading_d <= downloading;
			// A finished transfer of any kind marks the image as present
			if (downloading_d && !downloading) begin
				rom_loaded <= 1'b1;
			end
		end
	end

	// Only bytes of the ROM image reach the store
	always_ff @(posedge clk_48) begin
		if (reset) begin
			rom_we <= 1'b0;
		end else begin
			rom_we <= dl_wr & downloading & (dl_index == rom_index);
		end
	end

	// Core stays in reset until the ROM is in place
	always_ff @(posedge clk_48) begin
		if (reset) begin
			core_reset <= 1'b1;
		end else begin
			core_reset <= status.fields.reset_req | buttons[1] | ~rom_loaded;
		end
	end

endmodule

//--- source/rom_store.sv
`timescale 1ns/1ns

module rom_store #(
	parameter int rom_words      = 18432,
	parameter int prg_addr_width = 15,
	parameter int snd_addr_width = 12,
	parameter int snd_word_base  = 'h4000,
	parameter int dl_addr_width  = 25
) (
	input  logic                      clk_48,
	input  logic                      rom_we,
	input  logic [dl_addr_width-1:0]  wr_addr,
	input  logic [7:0]                wr_data,
	input  logic [prg_addr_width-1:0] prg_rom_addr,
	output logic [7:0]                prg_rom_do,
	input  logic [snd_addr_width-1:0] snd_rom_addr,
	output logic [7:0]                snd_rom_do
);

	localparam int word_width = $clog2(rom_words);
	localparam logic [word_width-1:0] snd_base = word_width'(snd_word_base);

	logic [15:0]           mem [rom_words];
	logic [word_width-1:0] wr_word;
	logic [word_width-1:0] prg_word_addr;
	logic [word_width-1:0] snd_word_addr;
	logic [15:0]           prg_word;
	logic [15:0]           snd_word;
	logic                  prg_hi;
	logic                  snd_hi;

	assign wr_word       = wr_addr[word_width:1];
	assign prg_word_addr = word_width'(prg_rom_addr[prg_addr_width-1:1]);
	assign snd_word_addr = word_width'(snd_rom_addr[snd_addr_width-1:1]) + snd_base;

	// Odd byte addresses fill the high lane
	always_ff @(posedge clk_48) begin
		if (rom_we && wr_word < word_width'(rom_words)) begin
			if (wr_addr[0]) begin
				mem[wr_word][15:8] <= wr_data;
			end else begin
				mem[wr_word][7:0] <= wr_data;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Read ports, word fetch then byte select
	// ------------------------------------------------------------------------

	always_ff @(posedge clk_48) begin
		prg_word   <= mem[prg_word_addr];
		prg_hi     <= prg_rom_addr[0];
		prg_rom_do <= prg_hi ? prg_word[15:8] : prg_word[7:0];
	end

	always_ff @(posedge clk_48) begin
		snd_word   <= mem[snd_word_addr];
		snd_hi     <= snd_rom_addr[0];
		snd_rom_do <= snd_hi ? snd_word[15:8] : snd_word[7:0];
	end

endmodule

//--- source/control_mapper.sv
`timescale 1ns/1ns

module control_mapper
	import arcade_glue_pkg::*;
(
	input  logic       clk_48,
	input  logic       reset,
	input  logic [7:0] joystick_0,
	input  logic [7:0] joystick_1,
	input  status_t    status,
	output logic [7:0] p1,
	output logic [7:0] p2,
	output logic [7:0] sys,
	output logic [7:0] dsw1,
	output logic [7:0] dsw2
);

	// Joystick bits: 0 right, 1 left, 2 down, 3 up, 4 fire, 6 start, 7 coin
	function automatic logic [7:0] player_byte(input logic [7:0] joy, input logic rot);
		logic up;
		logic down;
		logic left;
		logic right;
		if (rot) begin
			up    = joy[0];
			down  = joy[1];
			left  = joy[3];
			right = joy[2];
		end else begin
			up    = joy[3];
			down  = joy[2];
			left  = joy[1];
			right = joy[0];
		end
		return ~{3'b000, joy[4], down, up, left, right};
	endfunction

	always_ff @(posedge clk_48) begin
		if (reset) begin
			p1  <= 8'hff;
			p2  <= 8'hff;
			sys <= 8'hff;
		end else begin
			p1  <= player_byte(joystick_0, status.fields.rotate);
			p2  <= player_byte(joystick_1, status.fields.rotate);
			// Coins are active high on this board, tilt is never pressed
			sys <= {joystick_1[7], joystick_0[7], 3'b111, 1'b1, ~joystick_1[6], ~joystick_0[6]};
		end
	end

	// Menu defaults of zero map to the factory DIP settings
	always_ff @(posedge clk_48) begin
		dsw1 <= status.fields.dsw1 ^ 8'h3f;
		dsw2 <= ~status.fields.dsw2;
	end

endmodule

//--- source/btime_glue_top.sv
`timescale 1ns/1ns

module btime_glue_top
	import arcade_glue_pkg::*;
#(
	parameter int prg_addr_width = 15,
	parameter int snd_addr_width = 12,
	parameter int snd_word_base  = 'h4000,
	parameter int rom_words      = 18432,
	parameter int dl_addr_width  = 25
) (
	input  logic                      clk_48,
	input  logic                      reset,
	input  logic                      spi_sck,
	input  logic                      spi_ss2,
	input  logic                      spi_di,
	input  status_t                   status,
	input  logic [1:0]                buttons,
	input  logic [7:0]                joystick_0,
	input  logic [7:0]                joystick_1,
	input  logic [prg_addr_width-1:0] prg_rom_addr,
	input  logic [snd_addr_width-1:0] snd_rom_addr,
	output logic [7:0]                prg_rom_do,
	output logic [7:0]                snd_rom_do,
	output logic [7:0]                p1,
	output logic [7:0]                p2,
	output logic [7:0]                sys,
	output logic [7:0]                dsw1,
	output logic [7:0]                dsw2,
	output logic                      core_reset,
	output logic                      downloading
);

	logic [7:0]               dl_index;
	logic                     dl_wr;
	logic [dl_addr_width-1:0] dl_addr;
	logic [7:0]               dl_data;
	logic                     rom_we;

	spi_download #(
		.dl_addr_width (dl_addr_width)
	) u_spi_download (
		.clk_48      (clk_48),
		.reset       (reset),
		.spi_sck     (spi_sck),
		.spi_ss2     (spi_ss2),
		.spi_di      (spi_di),
		.downloading (downloading),
		.dl_index    (dl_index),
		.dl_wr       (dl_wr),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data)
	);

	rom_download_ctrl u_rom_download_ctrl (
		.clk_48      (clk_48),
		.reset       (reset),
		.downloading (downloading),
		.dl_wr       (dl_wr),
		.dl_index    (dl_index),
		.status      (status),
		.buttons     (buttons),
		.rom_we      (rom_we),
		.rom_loaded  (),
		.core_reset  (core_reset)
	);

	rom_store #(
		.rom_words      (rom_words),
		.prg_addr_width (prg_addr_width),
		.snd_addr_width (snd_addr_width),
		.snd_word_base  (snd_word_base),
		.dl_addr_width  (dl_addr_width)
	) u_rom_store (
		.clk_48       (clk_48),
		.rom_we       (rom_we),
		.wr_addr      (dl_addr),
		.wr_data      (dl_data),
		.prg_rom_addr (prg_rom_addr),
		.prg_rom_do   (prg_rom_do),
		.snd_rom_addr (snd_rom_addr),
		.snd_rom_do   (snd_rom_do)
	);

	control_mapper u_control_mapper (
		.clk_48     (clk_48),
		.reset      (reset),
		.joystick_0 (joystick_0),
		.joystick_1 (joystick_1),
		.status     (status),
		.p1         (p1),
		.p2         (p2),
		.sys        (sys),
		.dsw1       (dsw1),
		.dsw2       (dsw2)
	);

endmodule

//--- verification/btime_glue_props.sv
`timescale 1ns/1ns

module btime_glue_props (
	input logic clk_48,
	input logic reset,
	input logic downloading,
	input logic rom_we,
	input logic rom_loaded,
	input logic core_reset
);

	// A ROM write is a single strobe
	rom_we_single: assert property (@(posedge clk_48) disable iff (reset) rom_we |=> !rom_we)
		else $error("rom_we held for more than one clock");

	// The download stays open from the SPI byte until the store write lands
	rom_we_in_download: assert property (@(posedge clk_48) disable iff (reset)
		rom_we |-> $past(downloading) && downloading)
		else $error("rom_we outside an active download");

	// Core must never run without a loaded image
	reset_until_loaded: assert property (@(posedge clk_48) disable iff (reset)
		!rom_loaded |-> core_reset)
		else $error("core_reset low while rom_loaded is low");

endmodule

//--- verification/btime_glue_tb.sv
`timescale 1ns/1ns

module btime_glue_tb;
	import arcade_glue_pkg::*;

	logic        clk_48;
	logic        reset;
	logic        spi_sck;
	logic        spi_ss2;
	logic        spi_di;
	status_t     status;
	logic [1:0]  buttons;
	logic [7:0]  joystick_0;
	logic [7:0]  joystick_1;
	logic [14:0] prg_rom_addr;
	logic [11:0] snd_rom_addr;
	logic [7:0]  prg_rom_do;
	logic [7:0]  snd_rom_do;
	logic [7:0]  p1;
	logic [7:0]  p2;
	logic [7:0]  sys;
	logic [7:0]  dsw1;
	logic [7:0]  dsw2;
	logic        core_reset;
	logic        downloading;

	logic [7:0]  rom_model [65536];
	logic [39:0] map_expected;
	logic        map_check_en;
	logic        map_primed;
	int          map_checks;
	integer      seed;

	btime_glue_top u_btime_glue_top (.*);

	bind rom_download_ctrl btime_glue_props u_props (
		.clk_48      (clk_48),
		.reset       (reset),
		.downloading (downloading),
		.rom_we      (rom_we),
		.rom_loaded  (rom_loaded),
		.core_reset  (core_reset)
	);

	initial begin
		clk_48 = 1'b0;
		forever #50 clk_48 = ~clk_48;
	end

	// ------------------------------------------------------------------------
	// Reference model of the control mapper
	// ------------------------------------------------------------------------

	function automatic logic [7:0] player_ref(input logic [7:0] joy, input logic rot);
		logic r;
		logic l;
		logic d;
		logic u;
		{u, d, l, r} = {joy[3], joy[2], joy[1], joy[0]};
		// Rotated cabinet: up from right, down from left, left from up, right from down
		if (rot) begin
			{u, d, l, r} = {joy[0], joy[1], joy[3], joy[2]};
		end
		return {3'b111, ~joy[4], ~d, ~u, ~l, ~r};
	endfunction

	function automatic logic [39:0] mapper_ref(input logic [7:0] j0, input logic [7:0] j1,
			input status_t st);
		logic [7:0] sys_ref;
		sys_ref = {j1[7], j0[7], 4'b1111, ~j1[6], ~j0[6]};
		return {player_ref(j0, st.fields.rotate), player_ref(j1, st.fields.rotate),
			sys_ref, st.fields.dsw1 ^ 8'h3f, ~st.fields.dsw2};
	endfunction

	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first failure");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
			stop_run();
		end
	endtask

	// Outputs are stable at the falling edge, one clock after the inputs were sampled
	always @(negedge clk_48) begin
		if (map_check_en) begin
			if (map_primed) begin
				check_value(p1, map_expected[39:32], "p1");
				check_value(p2, map_expected[31:24], "p2");
				check_value(sys, map_expected[23:16], "sys");
				check_value(dsw1, map_expected[15:8], "dsw1");
				check_value(dsw2, map_expected[7:0], "dsw2");
				map_checks++;
			end
			map_expected = mapper_ref(joystick_0, joystick_1, status);
			map_primed   = 1'b1;
		end else begin
			map_primed = 1'b0;
		end
	end

	// ------------------------------------------------------------------------
	// Clock waits and SPI driver
	// ------------------------------------------------------------------------

	task automatic clocks(input int n);
		repeat (n) @(posedge clk_48);
		#10;
	endtask

	// which = 0 watches downloading, which = 1 watches core_reset
	task automatic wait_level(input bit which, input logic level, input int limit,
			input string what);
		int waited;
		waited = 0;
		while ((which ? core_reset : downloading) !== level) begin
			if (waited >= limit) begin
				$display("Timed out after %0d clocks waiting for %s", limit, what);
				stop_run();
			end else begin
				clocks(1);
				waited++;
			end
		end
	endtask

	task automatic spi_byte(input logic [7:0] value);
		for (int i = 7; i >= 0; i--) begin
			spi_sck = 1'b0;
			spi_di  = value[i];
			clocks(4);
			spi_sck = 1'b1;
			clocks(4);
		end
	endtask

	task automatic frame_open(input logic [7:0] cmd);
		spi_ss2 = 1'b0;
		clocks(4);
		spi_byte(cmd);
	endtask

	task automatic frame_close();
		spi_sck = 1'b0;
		clocks(4);
		spi_ss2 = 1'b1;
		clocks(8);
	endtask

	task automatic short_frame(input logic [7:0] cmd, input logic [7:0] arg);
		frame_open(cmd);
		spi_byte(arg);
		frame_close();
	endtask

	task automatic send_data(input int count, input int base, input bit keep);
		logic [7:0] value;
		frame_open(cmd_file_tx_dat);
		for (int i = 0; i < count; i++) begin
			value = 8'($random(seed));
			if (keep) begin
				rom_model[base + i] = value;
			end
			spi_byte(value);
		end
		frame_close();
	endtask

	task automatic read_prg(input int addr);
		prg_rom_addr = 15'(addr);
		clocks(2);
		check_value(prg_rom_do, rom_model[addr], $sformatf("program byte %0h", addr));
	endtask

	task automatic read_snd(input int addr);
		snd_rom_addr = 12'(addr);
		clocks(2);
		check_value(snd_rom_do, rom_model[32'h8000 + addr], $sformatf("sound byte %0h", addr));
	endtask

	initial begin
		seed         = 8;
		reset        = 1'b1;
		spi_sck      = 1'b0;
		spi_ss2      = 1'b1;
		spi_di       = 1'b0;
		status       = '0;
		buttons      = 2'b00;
		joystick_0   = 8'h00;
		joystick_1   = 8'h00;
		prg_rom_addr = '0;
		snd_rom_addr = '0;
		map_check_en = 1'b0;
		map_primed   = 1'b0;
		map_checks   = 0;
		repeat (16) @(posedge clk_48);
		#10;
		reset = 1'b0;

		for (int i = 0; i < 20; i++) begin
			check_value(core_reset, 1, "core_reset before download");
			check_value(downloading, 0, "downloading before download");
			clocks(1);
		end

		// ROM image at index 0, bytes 0 to 63
		short_frame(cmd_file_index, rom_index);
		short_frame(cmd_file_tx, 8'h01);
		wait_level(0, 1'b1, 20, "download start");
		send_data(64, 0, 1'b1);
		check_value(core_reset, 1, "core_reset during download");
		short_frame(cmd_file_tx, 8'h00);
		wait_level(0, 1'b0, 20, "download end");
		wait_level(1, 1'b0, 4, "core reset release after download");
		for (int a = 0; a < 64; a++) begin
			read_prg(a);
		end

		// Index 1 runs over the low area, then index 0 fills from byte 0x8000
		short_frame(cmd_file_index, 8'h01);
		short_frame(cmd_file_tx, 8'h01);
		wait_level(0, 1'b1, 20, "second download start");
		send_data(32'h8000, 0, 1'b0);
		short_frame(cmd_file_index, rom_index);
		send_data(64, 32'h8000, 1'b1);
		short_frame(cmd_file_tx, 8'h00);
		wait_level(0, 1'b0, 20, "second download end");
		for (int a = 0; a < 64; a++) begin
			read_prg(a);
		end
		for (int k = 0; k < 64; k++) begin
			read_snd(k);
		end

		map_check_en = 1'b1;
		for (int i = 0; i < 200; i++) begin
			joystick_0           = 8'($random(seed));
			joystick_1           = 8'($random(seed));
			status.raw           = $random(seed);
			status.fields.rotate = (i >= 100);
			clocks(1);
		end
		clocks(2);
		map_check_en = 1'b0;
		check_value(map_checks >= 200, 1, "number of mapper comparisons");
		status.raw = '0;
		wait_level(1, 1'b0, 4, "core reset clear after mapper test");

		status.fields.reset_req = 1'b1;
		wait_level(1, 1'b1, 2, "core reset from status");
		status.fields.reset_req = 1'b0;
		wait_level(1, 1'b0, 2, "core reset release from status");
		buttons[1] = 1'b1;
		wait_level(1, 1'b1, 2, "core reset from button");
		buttons[1] = 1'b0;
		wait_level(1, 1'b0, 2, "core reset release from button");

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- sources.f
source/arcade_glue_pkg.sv
source/spi_download.sv
source/rom_download_ctrl.sv
source/rom_store.sv
source/control_mapper.sv
source/btime_glue_top.sv
verification/btime_glue_props.sv
verification/btime_glue_tb.sv

//--- run_verilator.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module btime_glue_tb -f sources.f -o btime_glue_sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/btime_glue_sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "Simulation failed with status $sim_status"
	exit 1
fi

exit 0
